// ==== decode_unit.f ====
hdl/isa_pkg.sv
hdl/ctrl_pkg.sv
hdl/control_decoder.sv
hdl/imm_unit.sv
hdl/decode_stage.sv
hdl/decode_unit.sv
sim/clock_gen.sv
sim/decode_unit_properties.sv
sim/tb_decode_unit.sv

// ==== hdl/control_decoder.sv ====
module control_decoder (
	input  logic [5:0]                      opcode,
	input  logic [5:0]                      funct,
	output logic                            use_fpu,
	output logic                            reg_write,
	output logic [ctrl_pkg::wb_sel_w-1:0]   wb_sel,
	output logic [ctrl_pkg::src2_sel_w-1:0] src2_sel,
	output logic                            src1_rs,
	output logic [ctrl_pkg::alu_op_w-1:0]   alu_op,
	output logic [ctrl_pkg::dst_sel_w-1:0]  dst_sel,
	output logic [ctrl_pkg::pc_sel_w-1:0]   pc_sel,
	output logic                            mem_write,
	output logic                            mem_read,
	output logic                            uart_in,
	output logic                            uart_out
);
	import isa_pkg::*;
	import ctrl_pkg::*;

	logic shift_fn;	// sll, srl, sra
	logic alu_fn;	// r-type that writes rd
	logic fp_fn;	// known fp function

	assign shift_fn = funct inside {fn_sll, fn_srl, fn_sra};
	assign alu_fn   = shift_fn || (funct inside {fn_add, fn_sub, fn_and, fn_or, fn_xor, fn_slt});
	assign fp_fn    = funct inside {fmt_add, fmt_sub, fmt_mul, fmt_div, fmt_ceq, fmt_cle,
		fmt_clt};

	always_comb begin
		// no-write word unless the opcode says otherwise
		use_fpu   = 1'b0;
		reg_write = 1'b0;
		wb_sel    = '0;
		src2_sel  = src_none;
		src1_rs   = 1'b1;
		alu_op    = alu_none;
		dst_sel   = dst_rd;
		pc_sel    = pc_next;
		mem_write = 1'b0;
		mem_read  = 1'b0;
		uart_in   = 1'b0;
		uart_out  = 1'b0;
		case (opcode)
			op_sp: begin
				if (alu_fn) begin
					reg_write = 1'b1;
					wb_sel    = wb_alu;
					src2_sel  = shift_fn ? src_sa : src_rt;
					src1_rs   = ~shift_fn;	// shifts take rt as first operand
				end
				case (funct)
					fn_sll: alu_op = alu_sll;
					fn_srl: alu_op = alu_srl;
					fn_sra: alu_op = alu_sra;
					fn_add: alu_op = alu_add;
					fn_sub: alu_op = alu_sub;
					fn_and: alu_op = alu_and;
					fn_or:  alu_op = alu_or;
					fn_xor: alu_op = alu_xor;
					fn_slt: alu_op = alu_slt;
					fn_jr: begin
						alu_op   = alu_add;
						src2_sel = src_rt;
						pc_sel   = pc_jr;
					end
					default: ;
				endcase
			end
			op_jp: pc_sel = pc_jump;
			op_jal: begin
				reg_write = 1'b1;
				wb_sel    = wb_pc;
				dst_sel   = dst_link;
				pc_sel    = pc_jump;
			end
			op_beq, op_bne: begin
				src2_sel = src_rt;
				alu_op   = (opcode == op_beq) ? alu_beq : alu_bne;
				pc_sel   = pc_branch;
			end
			op_addi, op_andi, op_ori: begin
				reg_write = 1'b1;
				wb_sel    = wb_alu;
				src2_sel  = src_imm;
				dst_sel   = dst_rt;
				alu_op    = (opcode == op_addi) ? alu_add :
					(opcode == op_andi) ? alu_and : alu_or;
			end
			op_lw, op_lwc: begin
				use_fpu   = (opcode == op_lwc);
				reg_write = 1'b1;
				wb_sel    = wb_mem;
				src2_sel  = src_imm;
				alu_op    = alu_add;	// address = rs + imm
				dst_sel   = dst_rt;
				mem_read  = 1'b1;
			end
			op_sw, op_swc: begin
				use_fpu   = (opcode == op_swc);
				wb_sel    = wb_alu;
				src2_sel  = src_imm;
				alu_op    = alu_add;
				dst_sel   = dst_rt;
				mem_write = 1'b1;
			end
			op_in:  uart_in = 1'b1;
			op_out: uart_out = 1'b1;
			op_fpu: begin
				use_fpu = 1'b1;
				if (fp_fn) begin
					reg_write = 1'b1;
					wb_sel    = wb_alu;
					src2_sel  = src_rt;
				end
				case (funct)
					fmt_add: alu_op = alu_add;
					fmt_sub: alu_op = alu_sub;
					fmt_mul: alu_op = fpu_mul;
					fmt_div: alu_op = fpu_div;
					fmt_ceq: alu_op = fpu_ceq;
					fmt_cle: alu_op = fpu_cle;
					fmt_clt: alu_op = fpu_clt;
					default: ;
				endcase
			end
			default: ;
		endcase
	end

endmodule

// ==== hdl/ctrl_pkg.sv ====
package ctrl_pkg;

	// field widths of the control word
	localparam int wb_sel_w   = 2;
	localparam int src2_sel_w = 2;
	localparam int alu_op_w   = 4;
	localparam int dst_sel_w  = 2;
	localparam int pc_sel_w   = 2;

	// alu and fpu operation codes
	localparam logic [alu_op_w-1:0] alu_sll  = 4'd0;
	localparam logic [alu_op_w-1:0] alu_srl  = 4'd1;
	localparam logic [alu_op_w-1:0] alu_sra  = 4'd2;
	localparam logic [alu_op_w-1:0] alu_add  = 4'd3;
	localparam logic [alu_op_w-1:0] alu_sub  = 4'd4;
	localparam logic [alu_op_w-1:0] alu_and  = 4'd5;
	localparam logic [alu_op_w-1:0] alu_or   = 4'd6;
	localparam logic [alu_op_w-1:0] alu_xor  = 4'd7;
	localparam logic [alu_op_w-1:0] alu_slt  = 4'd8;
	localparam logic [alu_op_w-1:0] alu_beq  = 4'd9;
	localparam logic [alu_op_w-1:0] alu_bne  = 4'd10;
	localparam logic [alu_op_w-1:0] fpu_clt  = 4'd10;	// shares code with bne, fpu side
	localparam logic [alu_op_w-1:0] fpu_cle  = 4'd11;
	localparam logic [alu_op_w-1:0] fpu_ceq  = 4'd12;
	localparam logic [alu_op_w-1:0] fpu_div  = 4'd13;
	localparam logic [alu_op_w-1:0] fpu_mul  = 4'd14;
	localparam logic [alu_op_w-1:0] alu_none = 4'd15;	// no unit in use

	// writeback source
	localparam logic [wb_sel_w-1:0] wb_mem = 2'd1;
	localparam logic [wb_sel_w-1:0] wb_alu = 2'd2;
	localparam logic [wb_sel_w-1:0] wb_pc  = 2'd3;

	// second operand source
	localparam logic [src2_sel_w-1:0] src_rt   = 2'd0;
	localparam logic [src2_sel_w-1:0] src_sa   = 2'd1;
	localparam logic [src2_sel_w-1:0] src_imm  = 2'd2;
	localparam logic [src2_sel_w-1:0] src_none = 2'd3;

	// destination register
	localparam logic [dst_sel_w-1:0] dst_rd   = 2'd0;
	localparam logic [dst_sel_w-1:0] dst_rt   = 2'd1;
	localparam logic [dst_sel_w-1:0] dst_link = 2'd2;

	// next pc source
	localparam logic [pc_sel_w-1:0] pc_jr     = 2'd0;
	localparam logic [pc_sel_w-1:0] pc_jump   = 2'd1;
	localparam logic [pc_sel_w-1:0] pc_branch = 2'd2;
	localparam logic [pc_sel_w-1:0] pc_next   = 2'd3;

endpackage

// ==== hdl/decode_stage.sv ====
module decode_stage (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            in_valid,
	input  logic                            stall,
	input  isa_pkg::instr_t                 instr,
	input  logic                            dec_use_fpu,
	input  logic                            dec_reg_write,
	input  logic [ctrl_pkg::wb_sel_w-1:0]   dec_wb_sel,
	input  logic [ctrl_pkg::src2_sel_w-1:0] dec_src2_sel,
	input  logic                            dec_src1_rs,
	input  logic [ctrl_pkg::alu_op_w-1:0]   dec_alu_op,
	input  logic [ctrl_pkg::dst_sel_w-1:0]  dec_dst_sel,
	input  logic [ctrl_pkg::pc_sel_w-1:0]   dec_pc_sel,
	input  logic                            dec_mem_write,
	input  logic                            dec_mem_read,
	input  logic                            dec_uart_in,
	input  logic                            dec_uart_out,
	input  logic [31:0]                     sext_imm,
	input  logic [31:0]                     zext_imm,
	input  logic [31:0]                     sa_imm,
	input  logic [31:0]                     imm_branch_target,
	input  logic [31:0]                     imm_jump_target,
	output logic                            out_valid,
	output logic                            use_fpu,
	output logic                            reg_write,
	output logic [ctrl_pkg::wb_sel_w-1:0]   wb_sel,
	output logic [ctrl_pkg::src2_sel_w-1:0] src2_sel,
	output logic                            src1_rs,
	output logic [ctrl_pkg::alu_op_w-1:0]   alu_op,
	output logic [ctrl_pkg::pc_sel_w-1:0]   pc_sel,
	output logic                            mem_write,
	output logic                            mem_read,
	output logic                            uart_in,
	output logic                            uart_out,
	output logic [4:0]                      rs,
	output logic [4:0]                      rt,
	output logic [4:0]                      dst_reg,
	output logic [31:0]                     imm_val,
	output logic [31:0]                     branch_target,
	output logic [31:0]                     jump_target
);
	import isa_pkg::*;
	import ctrl_pkg::*;

	logic [31:0] imm_next;
	logic [4:0]  dst_next;

	always_comb begin
		case (dec_src2_sel)
			src_sa:  imm_next = sa_imm;
			src_imm: imm_next = (dec_alu_op == alu_and || dec_alu_op == alu_or) ?
				zext_imm : sext_imm;	// logical ops zero-extend
			default: imm_next = '0;
		endcase
	end

	always_comb begin
		case (dec_dst_sel)
			dst_rt:   dst_next = instr.i.rt;
			dst_link: dst_next = reg_link;
			default:  dst_next = instr.r.rd;
		endcase
	end

	// control state, cleared on a bubble
	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid <= 1'b0;
			reg_write <= 1'b0;
			pc_sel    <= pc_next;
			mem_write <= 1'b0;
			mem_read  <= 1'b0;
			uart_in   <= 1'b0;
			uart_out  <= 1'b0;
		end else if (!stall) begin
			out_valid <= in_valid;
			reg_write <= in_valid & dec_reg_write;
			pc_sel    <= in_valid ? dec_pc_sel : pc_next;
			mem_write <= in_valid & dec_mem_write;
			mem_read  <= in_valid & dec_mem_read;
			uart_in   <= in_valid & dec_uart_in;
			uart_out  <= in_valid & dec_uart_out;
		end
	end

	// payload
	always_ff @(posedge clk) begin
		if (!stall) begin
			use_fpu       <= dec_use_fpu;
			wb_sel        <= dec_wb_sel;
			src2_sel      <= dec_src2_sel;
			src1_rs       <= dec_src1_rs;
			alu_op        <= dec_alu_op;
			rs            <= instr.r.rs;
			rt            <= instr.r.rt;
			dst_reg       <= dst_next;
			imm_val       <= imm_next;
			branch_target <= imm_branch_target;
			jump_target   <= imm_jump_target;
		end
	end

endmodule

// ==== hdl/decode_unit.sv ====
module decode_unit (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            in_valid,
	input  logic [31:0]                     instr,
	input  logic [31:0]                     pc,
	input  logic                            stall,
	output logic                            out_valid,
	output logic                            use_fpu,
	output logic                            reg_write,
	output logic [ctrl_pkg::wb_sel_w-1:0]   wb_sel,
	output logic [ctrl_pkg::src2_sel_w-1:0] src2_sel,
	output logic                            src1_rs,
	output logic [ctrl_pkg::alu_op_w-1:0]   alu_op,
	output logic [ctrl_pkg::pc_sel_w-1:0]   pc_sel,
	output logic                            mem_write,
	output logic                            mem_read,
	output logic                            uart_in,
	output logic                            uart_out,
	output logic [4:0]                      rs,
	output logic [4:0]                      rt,
	output logic [4:0]                      dst_reg,
	output logic [31:0]                     imm_val,
	output logic [31:0]                     branch_target,
	output logic [31:0]                     jump_target
);
	import isa_pkg::*;
	import ctrl_pkg::*;

	instr_t                instr_u;	// field view of the raw word
	logic                  dec_use_fpu;
	logic                  dec_reg_write;
	logic [wb_sel_w-1:0]   dec_wb_sel;
	logic [src2_sel_w-1:0] dec_src2_sel;
	logic                  dec_src1_rs;
	logic [alu_op_w-1:0]   dec_alu_op;
	logic [dst_sel_w-1:0]  dec_dst_sel;
	logic [pc_sel_w-1:0]   dec_pc_sel;
	logic                  dec_mem_write;
	logic                  dec_mem_read;
	logic                  dec_uart_in;
	logic                  dec_uart_out;
	logic [31:0]           sext_imm;
	logic [31:0]           zext_imm;
	logic [31:0]           sa_imm;
	logic [31:0]           imm_branch_target;
	logic [31:0]           imm_jump_target;

	assign instr_u = instr;

	control_decoder control_decoder_inst (
		.opcode    (instr_u.r.op),
		.funct     (instr_u.r.funct),
		.use_fpu   (dec_use_fpu),
		.reg_write (dec_reg_write),
		.wb_sel    (dec_wb_sel),
		.src2_sel  (dec_src2_sel),
		.src1_rs   (dec_src1_rs),
		.alu_op    (dec_alu_op),
		.dst_sel   (dec_dst_sel),
		.pc_sel    (dec_pc_sel),
		.mem_write (dec_mem_write),
		.mem_read  (dec_mem_read),
		.uart_in   (dec_uart_in),
		.uart_out  (dec_uart_out)
	);

	imm_unit imm_unit_inst (
		.instr         (instr_u),
		.pc            (pc),
		.sext_imm      (sext_imm),
		.zext_imm      (zext_imm),
		.sa_imm        (sa_imm),
		.branch_target (imm_branch_target),
		.jump_target   (imm_jump_target)
	);

	decode_stage decode_stage_inst (
		.clk               (clk),
		.rst               (rst),
		.in_valid          (in_valid),
		.stall             (stall),
		.instr             (instr_u),
		.dec_use_fpu       (dec_use_fpu),
		.dec_reg_write     (dec_reg_write),
		.dec_wb_sel        (dec_wb_sel),
		.dec_src2_sel      (dec_src2_sel),
		.dec_src1_rs       (dec_src1_rs),
		.dec_alu_op        (dec_alu_op),
		.dec_dst_sel       (dec_dst_sel),
		.dec_pc_sel        (dec_pc_sel),
		.dec_mem_write     (dec_mem_write),
		.dec_mem_read      (dec_mem_read),
		.dec_uart_in       (dec_uart_in),
		.dec_uart_out      (dec_uart_out),
		.sext_imm          (sext_imm),
		.zext_imm          (zext_imm),
		.sa_imm            (sa_imm),
		.imm_branch_target (imm_branch_target),
		.imm_jump_target   (imm_jump_target),
		.out_valid         (out_valid),
		.use_fpu           (use_fpu),
		.reg_write         (reg_write),
		.wb_sel            (wb_sel),
		.src2_sel          (src2_sel),
		.src1_rs           (src1_rs),
		.alu_op            (alu_op),
		.pc_sel            (pc_sel),
		.mem_write         (mem_write),
		.mem_read          (mem_read),
		.uart_in           (uart_in),
		.uart_out          (uart_out),
		.rs                (rs),
		.rt                (rt),
		.dst_reg           (dst_reg),
		.imm_val           (imm_val),
		.branch_target     (branch_target),
		.jump_target       (jump_target)
	);

endmodule

// ==== hdl/imm_unit.sv ====
module imm_unit (
	input  isa_pkg::instr_t instr,
	input  logic [31:0]     pc,
	output logic [31:0]     sext_imm,
	output logic [31:0]     zext_imm,
	output logic [31:0]     sa_imm,
	output logic [31:0]     branch_target,
	output logic [31:0]     jump_target
);

	logic [31:0] pc_plus4;

	assign pc_plus4 = pc + 32'd4;

	assign sext_imm = {{16{instr.i.imm[15]}}, instr.i.imm};
	assign zext_imm = {16'h0000, instr.i.imm};	// andi, ori
	assign sa_imm   = {27'd0, instr.r.shamt};

	// offset counts words from the delay slot address
	assign branch_target = pc_plus4 + {sext_imm[29:0], 2'b00};

	// region bits of pc+4, word index from the low 26 bits
	assign jump_target = {pc_plus4[31:28], instr[25:0], 2'b00};

endmodule

// ==== hdl/isa_pkg.sv ====
package isa_pkg;

	// major opcodes
	localparam logic [5:0] op_sp   = 6'b000000;	// r-type, decoded by funct
	localparam logic [5:0] op_jp   = 6'b000010;
	localparam logic [5:0] op_jal  = 6'b000011;
	localparam logic [5:0] op_beq  = 6'b000100;
	localparam logic [5:0] op_bne  = 6'b000101;
	localparam logic [5:0] op_addi = 6'b001000;
	localparam logic [5:0] op_andi = 6'b001100;
	localparam logic [5:0] op_ori  = 6'b001101;
	localparam logic [5:0] op_lw   = 6'b100011;
	localparam logic [5:0] op_sw   = 6'b101011;
	localparam logic [5:0] op_in   = 6'b111011;	// uart receive
	localparam logic [5:0] op_out  = 6'b111100;	// uart send
	localparam logic [5:0] op_fpu  = 6'b010001;	// fp group, decoded by funct
	localparam logic [5:0] op_swc  = 6'b111001;	// coprocessor store
	localparam logic [5:0] op_lwc  = 6'b110001;	// coprocessor load

	// funct codes under op_sp
	localparam logic [5:0] fn_sll = 6'b000000;
	localparam logic [5:0] fn_srl = 6'b000010;
	localparam logic [5:0] fn_sra = 6'b000011;
	localparam logic [5:0] fn_jr  = 6'b001000;
	localparam logic [5:0] fn_add = 6'b100000;
	localparam logic [5:0] fn_sub = 6'b100010;
	localparam logic [5:0] fn_and = 6'b100100;
	localparam logic [5:0] fn_or  = 6'b100101;
	localparam logic [5:0] fn_xor = 6'b100110;
	localparam logic [5:0] fn_slt = 6'b101010;

	// fp function codes under op_fpu
	localparam logic [5:0] fmt_add = 6'b000000;
	localparam logic [5:0] fmt_sub = 6'b000001;
	localparam logic [5:0] fmt_mul = 6'b000010;
	localparam logic [5:0] fmt_div = 6'b000011;
	localparam logic [5:0] fmt_ceq = 6'b111100;
	localparam logic [5:0] fmt_cle = 6'b111101;
	localparam logic [5:0] fmt_clt = 6'b111110;

	localparam logic [4:0] reg_link = 5'd31;	// jal return address

	typedef struct packed {
		logic [5:0] op;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} r_fields_t;

	typedef struct packed {
		logic [5:0]  op;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm;
	} i_fields_t;

	// same 32 bits, two field layouts
	typedef union packed {
		r_fields_t r;
		i_fields_t i;
	} instr_t;

endpackage

// ==== run_sim.sh ====
#!/bin/sh
# build and run the decode unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --top-module tb_decode_unit \
	-f decode_unit.f -o tb_decode_unit
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_decode_unit > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^TEST PASS$" "$log"; then
	exit 0
fi
exit 1

// ==== sim/clock_gen.sv ====
module clock_gen (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;	// period 100
	end

	initial begin
		rst <= 1'b1;
		repeat (10) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

// ==== sim/decode_unit_properties.sv ====
module decode_unit_properties (
	input logic                            clk,
	input logic                            rst,
	input logic                            stall,
	input logic                            out_valid,
	input logic                            use_fpu,
	input logic                            reg_write,
	input logic [ctrl_pkg::wb_sel_w-1:0]   wb_sel,
	input logic [ctrl_pkg::src2_sel_w-1:0] src2_sel,
	input logic                            src1_rs,
	input logic [ctrl_pkg::alu_op_w-1:0]   alu_op,
	input logic [ctrl_pkg::pc_sel_w-1:0]   pc_sel,
	input logic                            mem_write,
	input logic                            mem_read,
	input logic                            uart_in,
	input logic                            uart_out,
	input logic [4:0]                      rs,
	input logic [4:0]                      rt,
	input logic [4:0]                      dst_reg,
	input logic [31:0]                     imm_val,
	input logic [31:0]                     branch_target,
	input logic [31:0]                     jump_target
);

	// a stalled stage holds every register
	hold_on_stall: assert property (@(posedge clk) (stall && !rst) |=> $stable({out_valid,
		use_fpu, reg_write, wb_sel, src2_sel, src1_rs, alu_op, pc_sel, mem_write, mem_read,
		uart_in, uart_out, rs, rt, dst_reg, imm_val, branch_target, jump_target}))
		else $error("decode outputs changed while stalled");

	strobes_idle: assert property (@(posedge clk) disable iff (rst)
		!out_valid |-> !(reg_write || mem_write || mem_read || uart_in || uart_out))
		else $error("strobe high in an empty slot");

	mem_exclusive: assert property (@(posedge clk) disable iff (rst) !(mem_write && mem_read))
		else $error("memory read and write in the same slot");

	valid_after_reset: assert property (@(posedge clk) rst |=> !out_valid)
		else $error("out_valid high after reset");

endmodule

bind decode_stage decode_unit_properties decode_unit_properties_inst (
	.clk           (clk),
	.rst           (rst),
	.stall         (stall),
	.out_valid     (out_valid),
	.use_fpu       (use_fpu),
	.reg_write     (reg_write),
	.wb_sel        (wb_sel),
	.src2_sel      (src2_sel),
	.src1_rs       (src1_rs),
	.alu_op        (alu_op),
	.pc_sel        (pc_sel),
	.mem_write     (mem_write),
	.mem_read      (mem_read),
	.uart_in       (uart_in),
	.uart_out      (uart_out),
	.rs            (rs),
	.rt            (rt),
	.dst_reg       (dst_reg),
	.imm_val       (imm_val),
	.branch_target (branch_target),
	.jump_target   (jump_target)
);

// ==== sim/tb_decode_unit.sv ====
module tb_decode_unit;
	import isa_pkg::*;
	import ctrl_pkg::*;

	localparam int num_tests    = 6;
	localparam int reset_cycles = 10;
	localparam int limit_cycles = num_tests * 20 + reset_cycles;

	logic                  clk;
	logic                  rst;
	logic                  in_valid;
	logic [31:0]           instr;
	logic [31:0]           pc;
	logic                  stall;
	logic                  out_valid;
	logic                  use_fpu;
	logic                  reg_write;
	logic [wb_sel_w-1:0]   wb_sel;
	logic [src2_sel_w-1:0] src2_sel;
	logic                  src1_rs;
	logic [alu_op_w-1:0]   alu_op;
	logic [pc_sel_w-1:0]   pc_sel;
	logic                  mem_write;
	logic                  mem_read;
	logic                  uart_in;
	logic                  uart_out;
	logic [4:0]            rs;
	logic [4:0]            rt;
	logic [4:0]            dst_reg;
	logic [31:0]           imm_val;
	logic [31:0]           branch_target;
	logic [31:0]           jump_target;
	int                    errors;
	logic [31:0]           rng_state;

	clock_gen clock_gen_inst (
		.clk (clk),
		.rst (rst)
	);

	decode_unit decode_unit_inst (
		.clk           (clk),
		.rst           (rst),
		.in_valid      (in_valid),
		.instr         (instr),
		.pc            (pc),
		.stall         (stall),
		.out_valid     (out_valid),
		.use_fpu       (use_fpu),
		.reg_write     (reg_write),
		.wb_sel        (wb_sel),
		.src2_sel      (src2_sel),
		.src1_rs       (src1_rs),
		.alu_op        (alu_op),
		.pc_sel        (pc_sel),
		.mem_write     (mem_write),
		.mem_read      (mem_read),
		.uart_in       (uart_in),
		.uart_out      (uart_out),
		.rs            (rs),
		.rt            (rt),
		.dst_reg       (dst_reg),
		.imm_val       (imm_val),
		.branch_target (branch_target),
		.jump_target   (jump_target)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic check_flag(input string name, input logic exp, input logic got);
		if (got !== exp) begin
			$display("FAIL %s exp %h got %h", name, exp, got);
			errors++;
		end
	endtask

	task automatic check_sel(input string name, input logic [pc_sel_w-1:0] exp,
		input logic [pc_sel_w-1:0] got);
		if (got !== exp) begin
			$display("FAIL %s exp %h got %h", name, exp, got);
			errors++;
		end
	endtask

	task automatic check_ctrl(input string name, input logic [alu_op_w-1:0] exp,
		input logic [alu_op_w-1:0] got);
		if (got !== exp) begin
			$display("FAIL %s exp %h got %h", name, exp, got);
			errors++;
		end
	endtask

	task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] got);
		if (got !== exp) begin
			$display("FAIL %s exp %h got %h", name, exp, got);
			errors++;
		end
	endtask

	task automatic check_reg(input string name, input logic [4:0] exp, input logic [4:0] got);
		if (got !== exp) begin
			$display("FAIL %s exp %h got %h", name, exp, got);
			errors++;
		end
	endtask

	// result visible at the next negedge
	task automatic send(input logic [31:0] w, input logic [31:0] p);
		@(posedge clk);
		instr    <= w;
		pc       <= p;
		in_valid <= 1'b1;
		@(posedge clk);	// captured here
		@(negedge clk);
	endtask

	task automatic expect_decode(
		input logic                  e_write,
		input logic [wb_sel_w-1:0]   e_wb,
		input logic [src2_sel_w-1:0] e_src2,
		input logic [alu_op_w-1:0]   e_alu,
		input logic [pc_sel_w-1:0]   e_pc,
		input logic                  e_fpu,
		input logic [3:0]            e_strobes	// mem_write mem_read uart_in uart_out
	);
		check_flag("out_valid", 1'b1, out_valid);
		check_flag("reg_write", e_write, reg_write);
		if (e_write)
			check_sel("wb_sel", e_wb, wb_sel);	// don't care without a write
		check_sel("src2_sel", e_src2, src2_sel);
		check_ctrl("alu_op", e_alu, alu_op);
		check_sel("pc_sel", e_pc, pc_sel);
		check_flag("use_fpu", e_fpu, use_fpu);
		check_flag("mem_write", e_strobes[3], mem_write);
		check_flag("mem_read", e_strobes[2], mem_read);
		check_flag("uart_in", e_strobes[1], uart_in);
		check_flag("uart_out", e_strobes[0], uart_out);
	endtask

	task automatic expect_idle();
		check_flag("out_valid", 1'b0, out_valid);
		check_flag("reg_write", 1'b0, reg_write);
		check_flag("mem_write", 1'b0, mem_write);
		check_flag("mem_read", 1'b0, mem_read);
		check_flag("uart_in", 1'b0, uart_in);
		check_flag("uart_out", 1'b0, uart_out);
		check_sel("pc_sel", pc_next, pc_sel);
	endtask

	task automatic rtype_ops();
		logic [5:0]          fn [10];
		logic [alu_op_w-1:0] op [10];
		logic [31:0]         w;
		logic                shift;
		fn = '{fn_add, fn_sub, fn_and, fn_or, fn_xor, fn_slt, fn_sll, fn_srl, fn_sra, fn_jr};
		op = '{alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_slt, alu_sll, alu_srl, alu_sra,
			alu_add};
		for (int k = 0; k < 10; k++) begin
			rng_state = xorshift(rng_state);
			w = {op_sp, rng_state[25:6], fn[k]};	// random rs rt rd shamt
			shift = (k >= 6) && (k <= 8);
			send(w, 32'h0000_1000);
			if (fn[k] == fn_jr) begin
				expect_decode(1'b0, wb_alu, src_rt, alu_add, pc_jr, 1'b0, 4'b0000);
			end else begin
				expect_decode(1'b1, wb_alu, shift ? src_sa : src_rt, op[k], pc_next, 1'b0,
					4'b0000);
				check_reg("dst_reg", w[15:11], dst_reg);
				check_flag("src1_rs", !shift, src1_rs);
				check_word("imm_val", shift ? {27'd0, w[10:6]} : 32'd0, imm_val);
			end
			check_reg("rs", w[25:21], rs);
			check_reg("rt", w[20:16], rt);
		end
	endtask

	task automatic itype_ops();
		send({op_addi, 5'd3, 5'd9, 16'hff80}, 32'h0000_2000);
		expect_decode(1'b1, wb_alu, src_imm, alu_add, pc_next, 1'b0, 4'b0000);
		check_reg("dst_reg", 5'd9, dst_reg);
		check_word("imm_val", 32'hffff_ff80, imm_val);
		send({op_andi, 5'd4, 5'd10, 16'h8001}, 32'h0000_2004);
		expect_decode(1'b1, wb_alu, src_imm, alu_and, pc_next, 1'b0, 4'b0000);
		check_reg("dst_reg", 5'd10, dst_reg);
		check_word("imm_val", 32'h0000_8001, imm_val);	// zero extended
		send({op_ori, 5'd5, 5'd11, 16'hf0f0}, 32'h0000_2008);
		expect_decode(1'b1, wb_alu, src_imm, alu_or, pc_next, 1'b0, 4'b0000);
		check_reg("dst_reg", 5'd11, dst_reg);
		check_word("imm_val", 32'h0000_f0f0, imm_val);
		send({op_lw, 5'd29, 5'd12, 16'hfffc}, 32'h0000_200c);
		expect_decode(1'b1, wb_mem, src_imm, alu_add, pc_next, 1'b0, 4'b0100);
		check_reg("dst_reg", 5'd12, dst_reg);
		check_word("imm_val", 32'hffff_fffc, imm_val);
		send({op_lwc, 5'd29, 5'd13, 16'h0010}, 32'h0000_2010);
		expect_decode(1'b1, wb_mem, src_imm, alu_add, pc_next, 1'b1, 4'b0100);
		check_reg("dst_reg", 5'd13, dst_reg);
		send({op_sw, 5'd29, 5'd14, 16'h8008}, 32'h0000_2014);
		expect_decode(1'b0, wb_alu, src_imm, alu_add, pc_next, 1'b0, 4'b1000);
		check_word("imm_val", 32'hffff_8008, imm_val);
		send({op_swc, 5'd29, 5'd15, 16'h0020}, 32'h0000_2018);
		expect_decode(1'b0, wb_alu, src_imm, alu_add, pc_next, 1'b1, 4'b1000);
	endtask

	task automatic flow_ops();
		logic [31:0] w;
		logic [31:0] p;
		p = 32'h0040_1000;
		w = {op_beq, 5'd1, 5'd2, 16'hfffe};	// backward branch
		send(w, p);
		expect_decode(1'b0, wb_alu, src_rt, alu_beq, pc_branch, 1'b0, 4'b0000);
		check_word("branch_target", 32'h0040_0ffc, branch_target);	// 0x401004 - 8
		w = {op_bne, 5'd3, 5'd4, 16'h0021};
		send(w, p);
		expect_decode(1'b0, wb_alu, src_rt, alu_bne, pc_branch, 1'b0, 4'b0000);
		check_word("branch_target", 32'h0040_1088, branch_target);	// 0x401004 + 0x84
		p = 32'h8fff_fffc;	// pc+4 moves into the next region
		w = {op_jp, 26'h2a5_5a5a};
		send(w, p);
		expect_decode(1'b0, wb_alu, src_none, alu_none, pc_jump, 1'b0, 4'b0000);
		check_word("jump_target", 32'h9a95_6968, jump_target);
		w = {op_jal, 26'h015_0c3c};
		send(w, p);
		expect_decode(1'b1, wb_pc, src_none, alu_none, pc_jump, 1'b0, 4'b0000);
		check_reg("dst_reg", 5'd31, dst_reg);
		check_word("jump_target", 32'h9054_30f0, jump_target);
	endtask

	task automatic fpu_uart_ops();
		logic [5:0]          fn [7];
		logic [alu_op_w-1:0] op [7];
		fn = '{fmt_add, fmt_sub, fmt_mul, fmt_div, fmt_ceq, fmt_cle, fmt_clt};
		op = '{alu_add, alu_sub, fpu_mul, fpu_div, fpu_ceq, fpu_cle, fpu_clt};
		for (int k = 0; k < 7; k++) begin
			send({op_fpu, 5'd2, 5'd4, 5'd6, 5'd0, fn[k]}, 32'h0000_4000);
			expect_decode(1'b1, wb_alu, src_rt, op[k], pc_next, 1'b1, 4'b0000);
			check_reg("dst_reg", 5'd6, dst_reg);
		end
		send({op_in, 26'd0}, 32'h0000_4004);
		expect_decode(1'b0, wb_alu, src_none, alu_none, pc_next, 1'b0, 4'b0010);
		send({op_out, 26'd0}, 32'h0000_4008);
		expect_decode(1'b0, wb_alu, src_none, alu_none, pc_next, 1'b0, 4'b0001);
		send({6'b111111, 26'h3ff_ffff}, 32'h0000_400c);	// unknown opcode
		expect_decode(1'b0, wb_alu, src_none, alu_none, pc_next, 1'b0, 4'b0000);
		send({op_sp, 20'h12345, 6'b111111}, 32'h0000_4010);	// unknown funct
		expect_decode(1'b0, wb_alu, src_none, alu_none, pc_next, 1'b0, 4'b0000);
	endtask

	task automatic stall_hold();
		logic [31:0] a;
		logic [31:0] b;
		a = {op_addi, 5'd1, 5'd7, 16'h8000};
		b = {op_ori, 5'd2, 5'd8, 16'h1234};
		send(a, 32'h0000_3000);
		@(posedge clk);
		stall <= 1'b1;
		instr <= b;
		pc    <= 32'h0000_3004;
		repeat (4) begin
			@(negedge clk);
			check_flag("out_valid", 1'b1, out_valid);
			check_ctrl("alu_op", alu_add, alu_op);
			check_reg("dst_reg", 5'd7, dst_reg);
			check_word("imm_val", 32'hffff_8000, imm_val);
		end
		@(posedge clk);
		stall <= 1'b0;
		@(posedge clk);	// b captured here
		@(negedge clk);
		expect_decode(1'b1, wb_alu, src_imm, alu_or, pc_next, 1'b0, 4'b0000);
		check_reg("dst_reg", 5'd8, dst_reg);
		check_word("imm_val", 32'h0000_1234, imm_val);
	endtask

	task automatic idle_slot();
		@(posedge clk);
		in_valid <= 1'b0;
		instr    <= {op_lw, 5'd1, 5'd2, 16'h0004};	// would raise mem_read if valid
		@(posedge clk);
		@(negedge clk);
		expect_idle();
	endtask

	initial begin
		repeat (limit_cycles) @(posedge clk);
		$display("timeout: tests still running after %0d cycles", limit_cycles);
		$display("TEST FAIL");
		$finish;
	end

	initial begin
		in_valid <= 1'b0;
		instr    <= '0;
		pc       <= '0;
		stall    <= 1'b0;
		errors = 0;
		rng_state = 32'hcf977d16;
		@(negedge rst);
		@(negedge clk);
		expect_idle();	// state right after reset
		rtype_ops();
		itype_ops();
		flow_ops();
		fpu_uart_ops();
		stall_hold();
		idle_slot();
		$display("errors: %0d", errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule
